// File: Makefile
TOP := tb_capture

all: run

build:
	verilator --binary --timing -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: files.f
+incdir+sim
verilog/xfer_pkg.sv
verilog/afifo.sv
verilog/frame_writer.sv
verilog/frame_reader.sv
verilog/capture_top.sv
sim/tb_capture.sv

// File: sim/capture_model.svh
`ifndef CAPTURE_MODEL_SVH
`define CAPTURE_MODEL_SVH

// ====================
// Reference state
// ====================
logic [15:0] sent_q[$];         // Every sample driven, oldest first
int          sent_count;
int          out_count;         // out_valid pulses seen
int          returned;          // credit_return pulses issued
int          frame_skip;        // Samples lost since the last frame start
int          sum_drops;         // Drops reported over all frames
bit          saturated;         // Some frame hit DROP_SAT
bit          expect_lossless;   // Drops must be zero right now
int          exp_seq;
logic [3:0]  frame_drops;       // Drops of the current frame
logic [3:0]  drv_chan;

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    string msg;
    if (exp !== act) begin
        msg = $sformatf("ERROR: %s expected 0x%0h got 0x%0h", name, exp, act);
        report_failure(msg);
    end
endtask

// One delivered sample against the model
task automatic score_output(input out_sample_t o);
    int  skip;
    int  exp_drops;
    bit  exp_first;
    skip = 0;
    while (sent_q.size() > 0 && sent_q[0] !== o.data) begin
        void'(sent_q.pop_front());  // Lost in the DUT
        skip++;
    end
    if (sent_q.size() == 0) begin
        report_failure("Output data is not found in the remaining sent stream");
    end else begin
        void'(sent_q.pop_front());
    end
    frame_skip += skip;

    exp_first = (out_count % FRAME_LEN) == 0;   // Every frame delivers all its samples
    check_value("out.first", 32'(exp_first), 32'(o.first));
    if (o.first) begin
        if (out_count > 0) begin
            exp_seq = (exp_seq + 1) % 256;
        end
        // Header counts losses since the previous frame start, saturating
        exp_drops = (frame_skip > DROP_SAT) ? DROP_SAT : frame_skip;
        check_value("out.drops", 32'(exp_drops), 32'(o.drops));
        frame_skip  = 0;
        frame_drops = o.drops;
        sum_drops  += o.drops;
        if (o.drops == 4'(DROP_SAT)) begin
            saturated = 1'b1;
        end
    end
    check_value("out.seq", 32'(exp_seq), 32'(o.seq));
    check_value("out.chan", 32'(drv_chan), 32'(o.chan));
    check_value("out.drops", 32'(frame_drops), 32'(o.drops));
    if (expect_lossless) begin
        check_value("out.drops", 32'h0, 32'(o.drops));
        check_value("skipped samples", 32'h0, 32'(skip));
    end
    out_count++;
    if (out_count > CREDIT_MAX + returned) begin
        report_failure("More samples delivered than credits allow");
    end
endtask

`endif

// File: sim/tb_capture.sv
`timescale 1ns/100ps
`default_nettype none

module tb_capture
    import xfer_pkg::*;
;
    localparam int N_RESET = 12;    // Sent with credits held back
    localparam int N_CLEAN = 40;
    localparam int N_PRESS = 200;
    localparam int N_FLUSH = 24;
    localparam int SLOW_GAP = 8;    // Worst w_clk cycles per slow sample
    localparam int FAST_GAP = 3;
    localparam int SETTLE   = 600;  // r_clk cycles of drain and idle windows
    // w_clk is 1.5 r_clk periods
    localparam int EXPECTED = ((N_RESET + N_CLEAN + N_FLUSH) * SLOW_GAP
                               + N_PRESS * FAST_GAP) * 3 / 2 + SETTLE;
    localparam int TIMEOUT_CYCLES = 4 * EXPECTED;

    logic        r_clk = 1'b0;
    logic        w_clk = 1'b0;
    logic        rst_;
    logic [3:0]  chan;
    logic        sample_valid;
    smp_t        sample;
    logic        credit_return;
    wire         out_valid;
    out_sample_t out_s;

    int          cycle_cnt;
    int          credit_mode;   // 0 hold, 1 prompt, 2 random stretches
    int          stretch_left;
    bit          withhold;

    `include "capture_model.svh"

    capture_top uut (
        .rst_          (rst_),
        .w_clk         (w_clk),
        .r_clk         (r_clk),
        .chan          (chan),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .out_valid     (out_valid),
        .out           (out_s),
        .credit_return (credit_return)
    );

    always #2 r_clk = ~r_clk;
    always #3 w_clk = ~w_clk;

    // ====================
    // Monitor and consumer
    // ====================
    always @(posedge r_clk) begin
        int held;
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            report_failure("Timeout, the run did not finish in the cycle limit");
        end
        if (rst_ && out_valid) begin
            score_output(out_s);
        end
        held = out_count - returned;    // Credits sitting with the consumer
        credit_return <= 1'b0;
        if (stretch_left == 0) begin
            stretch_left = $urandom_range(80, 10);
            withhold     = $urandom_range(1, 0) == 1;
        end else begin
            stretch_left--;
        end
        if (rst_ && held > 0) begin
            if (credit_mode == 1 ||
                (credit_mode == 2 && !withhold && $urandom_range(1, 0) == 1)) begin
                credit_return <= 1'b1;
                returned++;
            end
        end
    end

    // Sensor, one cycle valid then at least one idle cycle
    task automatic send_samples(input int n, input int max_gap);
        logic [15:0] d;
        int          gap;
        repeat (n) begin
            @(posedge w_clk);
            d = {8'($urandom), sent_count[7:0]};   // Low byte keeps data unique
            sample_valid <= 1'b1;
            sample.data  <= d;
            sent_q.push_back(d);
            sent_count++;
            @(posedge w_clk);
            sample_valid <= 1'b0;
            gap = $urandom_range(max_gap, 0);
            repeat (gap) @(posedge w_clk);
        end
    endtask

    task automatic wait_drained();
        while (sent_q.size() != 0) begin
            @(posedge r_clk);
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(32'h108d));
        rst_          = 1'b0;
        chan          = 4'($urandom);
        drv_chan      = chan;
        sample_valid  = 1'b0;
        sample        = '0;
        credit_return = 1'b0;
        credit_mode   = 0;
        repeat (5) @(posedge r_clk);
        rst_ <= 1'b1;
        @(posedge r_clk);
        check_value("out_valid", 32'h0, 32'(out_valid));

        // Reset credits only
        expect_lossless = 1'b1;
        send_samples(N_RESET, SLOW_GAP - 2);
        while (out_count < CREDIT_MAX) begin
            @(posedge r_clk);
        end
        repeat (150) @(posedge r_clk);
        check_value("output count", 32'(CREDIT_MAX), 32'(out_count));

        // Lossless stream
        credit_mode = 1;
        send_samples(N_CLEAN, SLOW_GAP - 2);
        wait_drained();

        // Back-pressure, drops expected
        expect_lossless = 1'b0;
        credit_mode     = 2;
        send_samples(N_PRESS, FAST_GAP - 2);
        credit_mode = 1;
        repeat (100) @(posedge r_clk);

        // Slow tail flushes the pending drop count
        send_samples(N_FLUSH, SLOW_GAP - 2);
        wait_drained();
        repeat (50) @(posedge r_clk);
        if (!saturated) begin
            check_value("outputs plus drops", 32'(sent_count), 32'(out_count + sum_drops));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/afifo.sv
`timescale 1ns/100ps
`default_nettype none

module afifo
    import xfer_pkg::*;
#(
    parameter int ADDR_BITS = FIFO_ADDR_BITS    // Depth is 2**ADDR_BITS
) (
    input  wire             rst_,       // Async, shared by both domains

    input  wire             w_clk,
    input  wire             w_push,     // Taken only with w_ready high
    input  wire fifo_word_t w_word,
    output wire             w_ready,    // Not full

    input  wire             r_clk,
    input  wire             r_pop,      // Taken only with r_ready high
    output fifo_word_t      r_word,     // Head word, valid with r_ready
    output wire             r_ready     // Not empty
);
    // Pointers carry one extra wrap bit
    logic [ADDR_BITS:0] w_bin;
    logic [ADDR_BITS:0] w_gray;
    logic [ADDR_BITS:0] w_bin_nxt;
    logic [ADDR_BITS:0] w_gray_nxt;
    logic [ADDR_BITS:0] w_rgray_meta;   // First sync stage
    logic [ADDR_BITS:0] w_rgray;        // Read pointer seen by writer
    logic               w_full;
    logic               w_take;

    logic [ADDR_BITS:0] r_bin;
    logic [ADDR_BITS:0] r_gray;
    logic [ADDR_BITS:0] r_bin_nxt;
    logic [ADDR_BITS:0] r_gray_nxt;
    logic [ADDR_BITS:0] r_wgray_meta;   // First sync stage
    logic [ADDR_BITS:0] r_wgray;        // Write pointer seen by reader
    logic               r_not_empty;
    logic               r_take;

    fifo_word_t mem [2**ADDR_BITS];

    // ====================
    // Write side
    // ====================
    assign w_take     = w_push && !w_full;
    assign w_bin_nxt  = w_take ? w_bin + 1'b1 : w_bin;
    assign w_gray_nxt = (w_bin_nxt >> 1) ^ w_bin_nxt;   // Bin to Gray

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            w_bin        <= '0;
            w_gray       <= '0;
            w_rgray_meta <= '0;
            w_rgray      <= '0;
            w_full       <= 1'b0;
        end else begin
            w_bin        <= w_bin_nxt;
            w_gray       <= w_gray_nxt;
            w_rgray_meta <= r_gray;         // Crosses from r_clk
            w_rgray      <= w_rgray_meta;
            // Full when writer is one lap ahead, top two Gray bits flipped
            w_full       <= (w_gray_nxt == {~w_rgray[ADDR_BITS -: 2],
                                             w_rgray[ADDR_BITS-2:0]});
        end
    end

    assign w_ready = !w_full;

    // ====================
    // Read side
    // ====================
    assign r_take     = r_pop && r_not_empty;
    assign r_bin_nxt  = r_take ? r_bin + 1'b1 : r_bin;
    assign r_gray_nxt = (r_bin_nxt >> 1) ^ r_bin_nxt;

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            r_bin        <= '0;
            r_gray       <= '0;
            r_wgray_meta <= '0;
            r_wgray      <= '0;
            r_not_empty  <= 1'b0;
        end else begin
            r_bin        <= r_bin_nxt;
            r_gray       <= r_gray_nxt;
            r_wgray_meta <= w_gray;         // Crosses from w_clk
            r_wgray      <= r_wgray_meta;
            r_not_empty  <= (r_gray_nxt != r_wgray);    // Empty on pointer match
        end
    end

    assign r_ready = r_not_empty;

    // ====================
    // RAM
    // ====================
    always_ff @(posedge w_clk) begin
        if (w_take) begin
            mem[w_bin[ADDR_BITS-1:0]] <= w_word;
        end
    end

    // Read ahead at next address so head word sits on r_word
    always_ff @(posedge r_clk) begin
        r_word <= mem[r_bin_nxt[ADDR_BITS-1:0]];
    end

endmodule

`default_nettype wire

// File: verilog/capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module capture_top
    import xfer_pkg::*;
(
    input  wire              rst_,          // Async, both domains
    input  wire              w_clk,         // Sensor clock
    input  wire              r_clk,         // System clock
    input  wire        [3:0] chan,
    input  wire              sample_valid,
    input  wire smp_t        sample,
    output wire              out_valid,
    output wire out_sample_t out,
    input  wire              credit_return
);
    // w_clk side
    wire             w_push;
    wire fifo_word_t w_word;
    wire             w_ready;

    // r_clk side
    wire             r_pop;
    wire fifo_word_t r_word;
    wire             r_ready;

    // ====================
    // Datapath
    // ====================
    frame_writer u_writer (
        .w_clk        (w_clk),
        .rst_         (rst_),
        .chan         (chan),
        .sample_valid (sample_valid),
        .sample       (sample),
        .w_push       (w_push),
        .w_word       (w_word),
        .w_ready      (w_ready)
    );

    afifo #(
        .ADDR_BITS (FIFO_ADDR_BITS)
    ) u_fifo (
        .rst_    (rst_),
        .w_clk   (w_clk),
        .w_push  (w_push),
        .w_word  (w_word),
        .w_ready (w_ready),
        .r_clk   (r_clk),
        .r_pop   (r_pop),
        .r_word  (r_word),
        .r_ready (r_ready)
    );

    frame_reader u_reader (
        .r_clk         (r_clk),
        .rst_          (rst_),
        .r_word        (r_word),
        .r_ready       (r_ready),
        .r_pop         (r_pop),
        .out_valid     (out_valid),
        .out           (out),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// File: verilog/frame_reader.sv
`timescale 1ns/100ps
`default_nettype none

module frame_reader
    import xfer_pkg::*;
(
    input  wire             r_clk,
    input  wire             rst_,
    input  wire fifo_word_t r_word,         // FIFO head word
    input  wire             r_ready,
    output wire             r_pop,
    output wire             out_valid,
    output out_sample_t     out,
    input  wire             credit_return   // One credit back per pulse
);
    logic [CREDIT_BITS-1:0] credits;        // Samples we may still send
    hdr_t                   tag_q;          // Latched header of current frame
    logic                   first_q;        // Next sample opens a frame
    logic                   out_valid_q;
    logic                   hdr_pop;
    logic                   smp_pop;

    // ====================
    // Pop control
    // ====================
    // Headers drain freely, samples need a credit
    assign r_pop   = r_ready && (r_word.is_hdr || (credits != '0));
    assign hdr_pop = r_pop && r_word.is_hdr;
    assign smp_pop = r_pop && !r_word.is_hdr;

    // ====================
    // Credit counter
    // ====================
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            credits <= CREDIT_BITS'(CREDIT_MAX);
        end else begin
            case ({smp_pop, credit_return})
                2'b10:   credits <= credits - 1'b1;  // Spent
                2'b01:   credits <= credits + 1'b1;  // Returned
                default: credits <= credits;         // Both or neither
            endcase
        end
    end

    // ====================
    // Tagging
    // ====================
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            out_valid_q <= 1'b0;
            first_q     <= 1'b0;
        end else begin
            out_valid_q <= smp_pop;     // One cycle behind the pop
            if (hdr_pop) begin
                first_q <= 1'b1;        // Arm for the frame's first sample
            end else if (smp_pop) begin
                first_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge r_clk) begin
        if (hdr_pop) begin
            tag_q <= r_word.payload.hdr;
        end
        if (smp_pop) begin
            out.chan  <= tag_q.chan;
            out.seq   <= tag_q.seq;
            out.drops <= tag_q.drops;
            out.first <= first_q;
            out.data  <= r_word.payload.smp.data;   // Sample view
        end
    end

    assign out_valid = out_valid_q;

endmodule

`default_nettype wire

// File: verilog/frame_writer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_writer
    import xfer_pkg::*;
(
    input  wire             w_clk,
    input  wire             rst_,
    input  wire       [3:0] chan,           // Static channel id
    input  wire             sample_valid,   // Never high two cycles running
    input  wire smp_t       sample,
    output wire             w_push,
    output fifo_word_t      w_word,
    input  wire             w_ready
);
    logic [FRAME_CNT_BITS-1:0] smp_cnt;     // Samples written in this frame
    logic [7:0]                seq_cnt;     // Current frame number
    logic [3:0]                drop_cnt;    // Saturating loss count
    logic                      hold_vld;    // First sample waiting behind header
    smp_t                      hold_q;
    logic                      hdr_slot;    // This edge carries a header
    logic                      want_push;
    logic                      drop;
    logic                      smp_push;
    logic                      frame_done;

    // ====================
    // Push decision
    // ====================
    // Frame start: header now, held sample on the next edge
    assign hdr_slot   = sample_valid && !hold_vld && (smp_cnt == '0);
    assign want_push  = hold_vld || sample_valid;
    assign w_push     = want_push && w_ready;   // Never push into a full FIFO
    assign drop       = want_push && !w_ready;  // Sensor can't wait, sample lost
    assign smp_push   = w_push && !hdr_slot;
    assign frame_done = smp_push && (smp_cnt == FRAME_CNT_BITS'(FRAME_LEN - 1));

    // Word mux, header view or sample view of the union
    always_comb begin
        w_word = '0;
        if (hdr_slot) begin
            w_word.is_hdr            = 1'b1;
            w_word.payload.hdr.seq   = seq_cnt;
            w_word.payload.hdr.drops = drop_cnt;
            w_word.payload.hdr.chan  = chan;
        end else begin
            w_word.is_hdr      = 1'b0;
            w_word.payload.smp = hold_vld ? hold_q : sample;
        end
    end

    // ====================
    // Frame state
    // ====================
    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            smp_cnt  <= '0;
            seq_cnt  <= '0;
            drop_cnt <= '0;
            hold_vld <= 1'b0;
        end else begin
            hold_vld <= hdr_slot && w_ready;    // Failed header retries later
            if (smp_push) begin
                smp_cnt <= frame_done ? '0 : smp_cnt + 1'b1;
            end
            if (frame_done) begin
                seq_cnt <= seq_cnt + 1'b1;      // Wraps at 256
            end
            if (drop) begin
                if (drop_cnt != 4'(DROP_SAT)) begin
                    drop_cnt <= drop_cnt + 1'b1;
                end
            end else if (hold_vld && w_ready) begin
                // Header's drops committed once its first sample lands
                drop_cnt <= '0;
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (hdr_slot) begin
            hold_q <= sample;
        end
    end

endmodule

`default_nettype wire

// File: verilog/xfer_pkg.sv
`default_nettype none

package xfer_pkg;

    // ====================
    // Sizing
    // ====================
    localparam int FIFO_ADDR_BITS = 4;                      // 16 word FIFO
    localparam int FRAME_LEN      = 8;                      // Samples per frame
    localparam int FRAME_CNT_BITS = $clog2(FRAME_LEN);      // Sample index in frame
    localparam int CREDIT_MAX     = 4;                      // Credits held after reset
    localparam int CREDIT_BITS    = $clog2(CREDIT_MAX + 1); // Counts 0..CREDIT_MAX
    localparam int DROP_SAT       = 15;                     // Drop field tops out here

    // ====================
    // FIFO word views
    // ====================
    typedef struct packed {
        logic [7:0] seq;    // Frame sequence, wraps at 256
        logic [3:0] drops;  // Samples lost since last header
        logic [3:0] chan;   // Source channel
    } hdr_t;

    typedef struct packed {
        logic [15:0] data;  // Raw sensor value
    } smp_t;

    // Same 16 bits, read per is_hdr
    typedef union packed {
        hdr_t hdr;
        smp_t smp;
    } payload_u;

    typedef struct packed {
        logic     is_hdr;   // Selects union view
        payload_u payload;
    } fifo_word_t;

    // Tagged sample towards the consumer
    typedef struct packed {
        logic [3:0]  chan;
        logic [7:0]  seq;
        logic [3:0]  drops;
        logic        first;  // First sample of its frame
        logic [15:0] data;
    } out_sample_t;

endpackage

`default_nettype wire
